/* design/response_control.sv */
//////////////////////////////////////////////////////////////////////
// Response control
// Routes latched responses by command type, then delays them so that
// the data delivered with them is handled first
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module response_control #(
  parameter int RSP_DELAY = 2
) (
  input  logic                      clock,
  input  logic                      rstn,
  input  logic                      enabled,
  // Latched response and its looked-up type
  input  logic                      lat_valid,
  input  logic [rsp_pkg::TAG_W-1:0] lat_tag,
  input  logic [7:0]                lat_code,
  input  rsp_pkg::cmd_type_t        lk_type,
  // Delayed response
  output logic                      out_valid,
  output logic [rsp_pkg::TAG_W-1:0] out_tag,
  output logic [7:0]                out_code,
  output rsp_pkg::cmd_type_t        out_cmd_type,
  // Routing strobes
  output logic                      read_response,
  output logic                      write_response,
  output logic                      wed_response,
  output logic                      restart_response
);

  // Bundle layout {valid, tag, code, type, read, write, wed, restart}
  localparam int TYPE_W = $bits(rsp_pkg::cmd_type_t);
  localparam int BUN_W  = 1 + rsp_pkg::TAG_W + 8 + TYPE_W + 4;

  logic [3:0]        route_sel;
  logic [BUN_W-1:0]  route_q;
  logic [BUN_W-1:0]  delay_q [RSP_DELAY];
  logic [BUN_W-1:0]  out_q;
  logic [TYPE_W-1:0] out_type_bits;

  //////////////////////////////////////////////////////////////////////
  // Routing decode
  //////////////////////////////////////////////////////////////////////

  // One-hot select, free entries route nowhere
  always_comb begin
    route_sel = 4'b0000;
    case (lk_type)
      rsp_pkg::CMD_READ:    route_sel = 4'b1000;
      rsp_pkg::CMD_WRITE:   route_sel = 4'b0100;
      rsp_pkg::CMD_WED:     route_sel = 4'b0010;
      rsp_pkg::CMD_RESTART: route_sel = 4'b0001;
      default:              route_sel = 4'b0000;
    endcase
  end

  // Routed stage
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      route_q <= '0;
    end else if (enabled && lat_valid) begin
      route_q <= {1'b1, lat_tag, lat_code, lk_type, route_sel};
    end else begin
      route_q <= '0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Delay line
  //////////////////////////////////////////////////////////////////////

  // All stages flush while disabled
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      for (int i = 0; i < RSP_DELAY; i++) begin
        delay_q[i] <= '0;
      end
    end else if (!enabled) begin
      for (int i = 0; i < RSP_DELAY; i++) begin
        delay_q[i] <= '0;
      end
    end else begin
      delay_q[0] <= route_q;
      for (int i = 1; i < RSP_DELAY; i++) begin
        delay_q[i] <= delay_q[i-1];
      end
    end
  end

  // Output register
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      out_q <= '0;
    end else if (enabled) begin
      out_q <= delay_q[RSP_DELAY-1];
    end else begin
      out_q <= '0;
    end
  end

  // Unpack onto the ports
  assign {out_valid, out_tag, out_code, out_type_bits,
          read_response, write_response, wed_response, restart_response} = out_q;
  assign out_cmd_type = rsp_pkg::cmd_type_t'(out_type_bits);

endmodule

`default_nettype wire

/* design/response_path_top.sv */
//////////////////////////////////////////////////////////////////////
// Response path top level
// Tag table, intake, routing and error stages of the response path
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module response_path_top #(
  parameter int RSP_DELAY = 2
) (
  input  logic                      clock,
  input  logic                      rstn,
  input  logic                      enable_in,
  // Command issue
  input  logic                      cmd_valid,
  input  logic [rsp_pkg::TAG_W-1:0] cmd_tag,
  input  rsp_pkg::cmd_type_t        cmd_type,
  // Host response
  input  logic                      rsp_valid,
  input  logic [rsp_pkg::TAG_W-1:0] rsp_tag,
  input  logic                      rsp_tag_parity,
  input  logic [7:0]                rsp_code,
  // Routed response
  output logic                      out_valid,
  output logic [rsp_pkg::TAG_W-1:0] out_tag,
  output logic [7:0]                out_code,
  output rsp_pkg::cmd_type_t        out_cmd_type,
  output logic                      read_response,
  output logic                      write_response,
  output logic                      wed_response,
  output logic                      restart_response,
  output logic [rsp_pkg::ERR_W-1:0] response_error
);

  logic                      enabled;
  logic                      lat_valid;
  logic [rsp_pkg::TAG_W-1:0] lat_tag;
  logic [7:0]                lat_code;
  logic                      parity_error;
  rsp_pkg::cmd_type_t        lk_type;

  // Command type per outstanding tag
  tag_table i_tag_table (
    .clock     (clock),
    .rstn      (rstn),
    .cmd_valid (cmd_valid),
    .cmd_tag   (cmd_tag),
    .cmd_type  (cmd_type),
    .rsp_valid (rsp_valid),
    .rsp_tag   (rsp_tag),
    .lk_type   (lk_type)
  );

  // Enable and response latch
  rsp_intake i_rsp_intake (
    .clock          (clock),
    .rstn           (rstn),
    .enable_in      (enable_in),
    .rsp_valid      (rsp_valid),
    .rsp_tag        (rsp_tag),
    .rsp_tag_parity (rsp_tag_parity),
    .rsp_code       (rsp_code),
    .enabled        (enabled),
    .lat_valid      (lat_valid),
    .lat_tag        (lat_tag),
    .lat_code       (lat_code),
    .parity_error   (parity_error)
  );

  // Routing and delay line
  response_control #(
    .RSP_DELAY (RSP_DELAY)
  ) i_response_control (
    .clock            (clock),
    .rstn             (rstn),
    .enabled          (enabled),
    .lat_valid        (lat_valid),
    .lat_tag          (lat_tag),
    .lat_code         (lat_code),
    .lk_type          (lk_type),
    .out_valid        (out_valid),
    .out_tag          (out_tag),
    .out_code         (out_code),
    .out_cmd_type     (out_cmd_type),
    .read_response    (read_response),
    .write_response   (write_response),
    .wed_response     (wed_response),
    .restart_response (restart_response)
  );

  // Error vector
  rsp_error_collect i_rsp_error_collect (
    .clock          (clock),
    .rstn           (rstn),
    .lat_valid      (lat_valid),
    .lat_code       (lat_code),
    .parity_error   (parity_error),
    .response_error (response_error)
  );

endmodule

`default_nettype wire

/* design/rsp_error_collect.sv */
//////////////////////////////////////////////////////////////////////
// Response error collect
// Code error classes and tag parity into a registered error vector
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module rsp_error_collect (
  input  logic                      clock,
  input  logic                      rstn,
  input  logic                      lat_valid,
  input  logic [7:0]                lat_code,
  input  logic                      parity_error,
  output logic [rsp_pkg::ERR_W-1:0] response_error
);

  logic [rsp_pkg::ERR_W-2:0] class_error;
  logic [rsp_pkg::ERR_W-1:0] detected;

  //////////////////////////////////////////////////////////////////////
  // Error pipeline
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      class_error    <= '0;
      detected       <= '0;
      response_error <= '0;
    end else begin
      // Classes only for a real response, in step with the parity register
      if (lat_valid) begin
        class_error <= rsp_pkg::cmd_response_error_type(lat_code);
      end else begin
        class_error <= '0;
      end
      // Parity on top, classes below
      detected       <= {parity_error, class_error};
      response_error <= detected;
    end
  end

endmodule

`default_nettype wire

/* design/rsp_intake.sv */
//////////////////////////////////////////////////////////////////////
// Response intake
// Enable register, response latch and odd parity check on the tag
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module rsp_intake (
  input  logic                      clock,
  input  logic                      rstn,
  input  logic                      enable_in,
  // Host response
  input  logic                      rsp_valid,
  input  logic [rsp_pkg::TAG_W-1:0] rsp_tag,
  input  logic                      rsp_tag_parity,
  input  logic [7:0]                rsp_code,
  // Latched response
  output logic                      enabled,
  output logic                      lat_valid,
  output logic [rsp_pkg::TAG_W-1:0] lat_tag,
  output logic [7:0]                lat_code,
  output logic                      parity_error
);

  // Parity value of an all-zero tag under odd parity
  localparam logic ODD_PARITY = 1'b1;

  logic lat_parity;
  logic calc_parity;

  // Enable, one cycle behind the input
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      enabled <= 1'b0;
    end else begin
      enabled <= enable_in;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Input latch
  //////////////////////////////////////////////////////////////////////

  // Idle cycles load zeros, parity bit parks at the odd value
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      lat_valid  <= 1'b0;
      lat_tag    <= '0;
      lat_code   <= '0;
      lat_parity <= ODD_PARITY;
    end else if (enabled && rsp_valid) begin
      lat_valid  <= 1'b1;
      lat_tag    <= rsp_tag;
      lat_code   <= rsp_code;
      lat_parity <= rsp_tag_parity;
    end else begin
      lat_valid  <= 1'b0;
      lat_tag    <= '0;
      lat_code   <= '0;
      lat_parity <= ODD_PARITY;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Parity check
  //////////////////////////////////////////////////////////////////////

  // Bit that makes the total count of ones odd
  assign calc_parity = ~^lat_tag;

  // Mismatch between received and computed bit
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      parity_error <= 1'b0;
    end else begin
      parity_error <= lat_parity ^ calc_parity;
    end
  end

endmodule

`default_nettype wire

/* design/rsp_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Response path package
// Tag width, command and response code encodings, error classes
//////////////////////////////////////////////////////////////////////
`default_nettype none

package rsp_pkg;

  // Tag and error vector widths
  localparam int TAG_W = 8;
  localparam int ERR_W = 7;

  // Command type stored per tag, NONE marks a free entry
  typedef enum logic [2:0] {
    CMD_NONE    = 3'd0,
    CMD_READ    = 3'd1,
    CMD_WRITE   = 3'd2,
    CMD_WED     = 3'd3,
    CMD_RESTART = 3'd4
  } cmd_type_t;

  // Host response codes
  typedef enum logic [7:0] {
    RSP_DONE    = 8'd0,
    RSP_AERROR  = 8'd1,
    RSP_DERROR  = 8'd3,
    RSP_NLOCK   = 8'd4,
    RSP_NRES    = 8'd5,
    RSP_FLUSHED = 8'd6,
    RSP_FAULT   = 8'd7,
    RSP_FAILED  = 8'd8,
    RSP_PAGED   = 8'd10
  } rsp_code_t;

  // Error class vector of a response code, zero for DONE and unknown codes
  function automatic logic [ERR_W-2:0] cmd_response_error_type(input logic [7:0] code);
    logic [ERR_W-2:0] err;
    err = '0;
    case (code)
      RSP_AERROR:           err[5] = 1'b1;
      RSP_DERROR:           err[4] = 1'b1;
      RSP_NLOCK, RSP_NRES:  err[3] = 1'b1;
      RSP_FLUSHED:          err[2] = 1'b1;
      RSP_FAULT, RSP_PAGED: err[1] = 1'b1;
      RSP_FAILED:           err[0] = 1'b1;
      default:              err    = '0;
    endcase
    return err;
  endfunction

endpackage

`default_nettype wire

/* design/tag_table.sv */
//////////////////////////////////////////////////////////////////////
// Tag table
// One command type per tag, set on issue, read and freed on response
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tag_table (
  input  logic                      clock,
  input  logic                      rstn,
  // Command issue side
  input  logic                      cmd_valid,
  input  logic [rsp_pkg::TAG_W-1:0] cmd_tag,
  input  rsp_pkg::cmd_type_t        cmd_type,
  // Response lookup side
  input  logic                      rsp_valid,
  input  logic [rsp_pkg::TAG_W-1:0] rsp_tag,
  output rsp_pkg::cmd_type_t        lk_type
);

  // One entry for every possible tag
  localparam int DEPTH = 1 << rsp_pkg::TAG_W;

  rsp_pkg::cmd_type_t type_mem [DEPTH];

  //////////////////////////////////////////////////////////////////////
  // Entry update
  //////////////////////////////////////////////////////////////////////

  // Free on response first, issue overrides when both hit one tag
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      for (int i = 0; i < DEPTH; i++) begin
        type_mem[i] <= rsp_pkg::CMD_NONE;
      end
    end else begin
      if (rsp_valid) begin
        type_mem[rsp_tag] <= rsp_pkg::CMD_NONE;
      end
      // Later assignment wins, so the new command is kept
      if (cmd_valid) begin
        type_mem[cmd_tag] <= cmd_type;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Lookup
  //////////////////////////////////////////////////////////////////////

  // Registered on the same edge as the intake latch
  // Stale or duplicate responses see the freed entry
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      lk_type <= rsp_pkg::CMD_NONE;
    end else begin
      if (rsp_valid) begin
        lk_type <= type_mem[rsp_tag];
      end else begin
        lk_type <= rsp_pkg::CMD_NONE;
      end
    end
  end

endmodule

`default_nettype wire

/* project.f */
design/rsp_pkg.sv
design/tag_table.sv
design/rsp_intake.sv
design/response_control.sv
design/rsp_error_collect.sv
design/response_path_top.sv
verif/response_path_asserts.sv
verif/response_path_tb.sv

/* verif/response_path_asserts.sv */
//////////////////////////////////////////////////////////////////////
// Response path assertions
// Strobe exclusivity and output silence while disabled
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module response_path_asserts (
  input logic clock,
  input logic rstn,
  input logic enable_in,
  input logic out_valid,
  input logic read_response,
  input logic write_response,
  input logic wed_response,
  input logic restart_response
);

  logic [3:0] strobes;

  assign strobes = {read_response, write_response, wed_response, restart_response};

  // Never two routes at once
  a_one_strobe: assert property (@(posedge clock) disable iff (!rstn)
    $onehot0(strobes))
    else $error("More than one routing strobe high");

  // A strobe always comes with its response
  a_strobe_valid: assert property (@(posedge clock) disable iff (!rstn)
    (|strobes) |-> out_valid)
    else $error("Routing strobe without out_valid");

  // Flushed pipeline stays quiet
  a_disable_quiet: assert property (@(posedge clock) disable iff (!rstn)
    (!enable_in) [*3] |-> ##2 !out_valid)
    else $error("out_valid high after enable was dropped");

endmodule

bind response_path_top response_path_asserts i_response_path_asserts (
  .clock            (clock),
  .rstn             (rstn),
  .enable_in        (enable_in),
  .out_valid        (out_valid),
  .read_response    (read_response),
  .write_response   (write_response),
  .wed_response     (wed_response),
  .restart_response (restart_response)
);

`default_nettype wire

/* verif/response_path_tb.sv */
//////////////////////////////////////////////////////////////////////
// Response path testbench
// Directed tests for routing, tag freeing, errors and disable
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module response_path_tb;

  localparam int WAIT_LIMIT = 20;

  logic                            clock;
  logic                            rstn;
  logic                            enable_in;
  logic                            cmd_valid;
  logic [rsp_pkg::TAG_W-1:0]       cmd_tag;
  rsp_pkg::cmd_type_t              cmd_type;
  logic                            rsp_valid;
  logic [rsp_pkg::TAG_W-1:0]       rsp_tag;
  logic                            rsp_tag_parity;
  logic [7:0]                      rsp_code;
  logic                            out_valid;
  logic [rsp_pkg::TAG_W-1:0]       out_tag;
  logic [7:0]                      out_code;
  rsp_pkg::cmd_type_t              out_cmd_type;
  logic                            read_response;
  logic                            write_response;
  logic                            wed_response;
  logic                            restart_response;
  logic [rsp_pkg::ERR_W-1:0]       response_error;

  int errors = 0;

  // Every listed response code
  logic [7:0] code_list [9] = '{8'd0, 8'd1, 8'd3, 8'd4, 8'd5, 8'd6, 8'd7, 8'd8, 8'd10};

  response_path_top #(
    .RSP_DELAY (2)
  ) i_response_path_top (
    .clock            (clock),
    .rstn             (rstn),
    .enable_in        (enable_in),
    .cmd_valid        (cmd_valid),
    .cmd_tag          (cmd_tag),
    .cmd_type         (cmd_type),
    .rsp_valid        (rsp_valid),
    .rsp_tag          (rsp_tag),
    .rsp_tag_parity   (rsp_tag_parity),
    .rsp_code         (rsp_code),
    .out_valid        (out_valid),
    .out_tag          (out_tag),
    .out_code         (out_code),
    .out_cmd_type     (out_cmd_type),
    .read_response    (read_response),
    .write_response   (write_response),
    .wed_response     (wed_response),
    .restart_response (restart_response),
    .response_error   (response_error)
  );

  // 20 ns clock
  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  // Next edge plus drive delay
  task automatic step();
    @(posedge clock);
    #2;
  endtask

  task automatic report_mismatch(input string msg);
    $display("FAIL %0t: %s", $time, msg);
    errors++;
  endtask

  // Bit that makes the count of ones odd
  function automatic logic odd_parity(input logic [rsp_pkg::TAG_W-1:0] tag);
    return ~(^tag);
  endfunction

  // Error classes straight from the code table
  function automatic logic [5:0] expected_class(input logic [7:0] code);
    case (code)
      8'd1:        return 6'b100000;
      8'd3:        return 6'b010000;
      8'd4, 8'd5:  return 6'b001000;
      8'd6:        return 6'b000100;
      8'd7, 8'd10: return 6'b000010;
      8'd8:        return 6'b000001;
      default:     return 6'b000000;
    endcase
  endfunction

  // Expected {read, write, wed, restart}
  function automatic logic [3:0] strobes_for(input rsp_pkg::cmd_type_t t);
    case (t)
      rsp_pkg::CMD_READ:    return 4'b1000;
      rsp_pkg::CMD_WRITE:   return 4'b0100;
      rsp_pkg::CMD_WED:     return 4'b0010;
      rsp_pkg::CMD_RESTART: return 4'b0001;
      default:              return 4'b0000;
    endcase
  endfunction

  // One cycle command issue pulse
  task automatic issue_cmd(input logic [rsp_pkg::TAG_W-1:0] tag,
                           input rsp_pkg::cmd_type_t t);
    cmd_valid = 1'b1;
    cmd_tag   = tag;
    cmd_type  = t;
    step();
    cmd_valid = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Single response with full checks
  //////////////////////////////////////////////////////////////////////

  // Error pulse expected at edge 4
  // Delivery expected at edge 5
  // Error vector quiet on every other edge
  task automatic check_response(input logic [rsp_pkg::TAG_W-1:0] tag, input logic flip,
                                input logic [7:0] code, input rsp_pkg::cmd_type_t exp_type);
    logic [rsp_pkg::ERR_W-1:0] exp_err;
    int                        edges;
    bit                        seen;
    exp_err        = {flip, expected_class(code)};
    rsp_valid      = 1'b1;
    rsp_tag        = tag;
    rsp_tag_parity = odd_parity(tag) ^ flip;
    rsp_code       = code;
    edges          = 0;
    seen           = 0;
    while (!seen && edges < WAIT_LIMIT) begin
      step();
      edges++;
      rsp_valid = 1'b0;
      if (edges == 4) begin
        if (response_error !== exp_err)
          report_mismatch($sformatf("code %0d error %b, expected %b", code,
                                    response_error, exp_err));
      end else if (response_error !== 7'd0) begin
        report_mismatch($sformatf("error %b outside its pulse", response_error));
      end
      if (out_valid) seen = 1;
    end
    if (!seen) begin
      $display("Timed out waiting for out_valid of tag %h", tag);
      errors++;
    end else begin
      if (edges != 5)
        report_mismatch($sformatf("tag %h out after %0d edges", tag, edges));
      if (out_tag !== tag || out_code !== code || out_cmd_type !== exp_type)
        report_mismatch($sformatf("got tag %h code %0d type %0d, expected %h %0d %0d",
                                  out_tag, out_code, out_cmd_type, tag, code, exp_type));
      if ({read_response, write_response, wed_response, restart_response}
          !== strobes_for(exp_type))
        report_mismatch($sformatf("wrong strobes for tag %h", tag));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  // One response per command type
  task automatic routing_test();
    rsp_pkg::cmd_type_t        t;
    logic [rsp_pkg::TAG_W-1:0] tag;
    for (int i = 1; i <= 4; i++) begin
      t   = rsp_pkg::cmd_type_t'(i);
      tag = 8'($urandom_range(255));
      issue_cmd(tag, t);
      check_response(tag, 1'b0, code_list[$urandom_range(8)], t);
    end
  endtask

  // Duplicate response and never issued tag both find a free entry
  task automatic free_test();
    issue_cmd(8'h3c, rsp_pkg::CMD_WRITE);
    check_response(8'h3c, 1'b0, 8'd0, rsp_pkg::CMD_WRITE);
    check_response(8'h3c, 1'b0, 8'd0, rsp_pkg::CMD_NONE);
  endtask

  // Walk every listed code
  task automatic code_test();
    logic [rsp_pkg::TAG_W-1:0] tag;
    for (int i = 0; i < 9; i++) begin
      tag = 8'($urandom_range(255));
      issue_cmd(tag, rsp_pkg::CMD_READ);
      check_response(tag, 1'b0, code_list[i], rsp_pkg::CMD_READ);
    end
  endtask

  // Flipped parity bit still routed
  task automatic parity_test();
    issue_cmd(8'h5a, rsp_pkg::CMD_WED);
    check_response(8'h5a, 1'b1, 8'd0, rsp_pkg::CMD_WED);
  endtask

  // Eight back to back responses
  // Stride of 17 keeps the tags distinct
  task automatic pipeline_test();
    logic [rsp_pkg::TAG_W-1:0] tags  [8];
    logic [7:0]                codes [8];
    rsp_pkg::cmd_type_t        types [8];
    logic [rsp_pkg::TAG_W-1:0] base;
    int                        n;
    int                        edges;
    base = 8'($urandom_range(255));
    for (int i = 0; i < 8; i++) begin
      tags[i]  = base + 8'(i * 17);
      codes[i] = code_list[$urandom_range(8)];
      types[i] = rsp_pkg::cmd_type_t'($urandom_range(4, 1));
      issue_cmd(tags[i], types[i]);
    end
    n     = 0;
    edges = 0;
    while (n < 8 && edges < WAIT_LIMIT) begin
      // Drive one response per cycle for the first eight cycles
      if (edges < 8) begin
        rsp_valid      = 1'b1;
        rsp_tag        = tags[edges];
        rsp_tag_parity = odd_parity(tags[edges]);
        rsp_code       = codes[edges];
      end else begin
        rsp_valid = 1'b0;
      end
      step();
      edges++;
      if (out_valid) begin
        if (edges != 5 + n)
          report_mismatch($sformatf("response %0d out at edge %0d", n, edges));
        if (out_tag !== tags[n] || out_code !== codes[n] || out_cmd_type !== types[n])
          report_mismatch($sformatf("response %0d out of order, tag %h", n, out_tag));
        if ({read_response, write_response, wed_response, restart_response}
            !== strobes_for(types[n]))
          report_mismatch($sformatf("wrong strobes on response %0d", n));
        n++;
      end
    end
    rsp_valid = 1'b0;
    if (n < 8) begin
      $display("Timed out with %0d of 8 pipelined responses delivered", n);
      errors++;
    end
  endtask

  task automatic watch_quiet(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      step();
      if (out_valid) report_mismatch("out_valid while disabled");
    end
  endtask

  task automatic disable_test();
    // Responses ignored while disabled
    enable_in = 1'b0;
    repeat (3) step();
    issue_cmd(8'h21, rsp_pkg::CMD_READ);
    rsp_valid      = 1'b1;
    rsp_tag        = 8'h21;
    rsp_tag_parity = odd_parity(8'h21);
    step();
    rsp_valid = 1'b0;
    watch_quiet(10);
    // Re-enable and let the enable register follow
    enable_in = 1'b1;
    repeat (2) step();
    // Drop enable with one response at the routed stage
    issue_cmd(8'h42, rsp_pkg::CMD_WRITE);
    rsp_valid      = 1'b1;
    rsp_tag        = 8'h42;
    rsp_tag_parity = odd_parity(8'h42);
    step();
    rsp_valid = 1'b0;
    step();
    enable_in = 1'b0;
    watch_quiet(10);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(6));
    rstn           = 1'b0;
    enable_in      = 1'b0;
    cmd_valid      = 1'b0;
    cmd_tag        = 8'd0;
    cmd_type       = rsp_pkg::CMD_NONE;
    rsp_valid      = 1'b0;
    rsp_tag        = 8'd0;
    rsp_tag_parity = 1'b1;
    rsp_code       = 8'd0;
    repeat (2) @(posedge clock);
    #2;
    rstn = 1'b1;
    // All outputs quiet out of reset
    if (out_valid !== 1'b0 || out_tag !== 8'd0 || out_code !== 8'd0 ||
        out_cmd_type !== rsp_pkg::CMD_NONE || response_error !== 7'd0 ||
        {read_response, write_response, wed_response, restart_response} !== 4'd0)
      report_mismatch("outputs not zero after reset");
    enable_in = 1'b1;
    step();
    step();
    // Never issued tag after reset
    check_response(8'ha5, 1'b0, 8'd0, rsp_pkg::CMD_NONE);
    routing_test();
    free_test();
    code_test();
    parity_test();
    pipeline_test();
    disable_test();
    $display("Checks complete with %0d errors", errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
